// ==== compile.f ====
hdl/alu_pkg.sv
hdl/alu_shifter.sv
hdl/alu_multiplier.sv
hdl/alu_divider.sv
hdl/alu_core.sv
hdl/alu_stage.sv
tests/alu_properties.sv
tests/alu_tb.sv

// ==== hdl/alu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_core (
    input  wire alu_pkg::alu_op_t         op,
    input  wire logic [alu_pkg::xlen-1:0] op1,
    input  wire logic [alu_pkg::xlen-1:0] op2,
    output logic      [alu_pkg::xlen-1:0] result,
    output logic                          illegal
);
    import alu_pkg::*;

    logic [xlen-1:0]   sum;
    logic [xlen-1:0]   diff;
    logic              lt_s;
    logic              lt_u;
    logic [1:0]        shift_kind;
    logic [xlen-1:0]   shifted;
    logic              mul_a_signed;
    logic              mul_b_signed;
    logic [2*xlen-1:0] product;
    logic              div_signed;
    logic [xlen-1:0]   quotient;
    logic [xlen-1:0]   remainder;

    assign sum  = op1 + op2;
    assign diff = op1 - op2;
    assign lt_s = $signed(op1) < $signed(op2);
    assign lt_u = op1 < op2;

    always_comb begin
        case (op)
            op_srl:  shift_kind = shift_srl;
            op_sra:  shift_kind = shift_sra;
            default: shift_kind = shift_sll;
        endcase
    end

    assign mul_a_signed = (op == op_mul) || (op == op_mulh) || (op == op_mulhsu);
    assign mul_b_signed = (op == op_mul) || (op == op_mulh);
    assign div_signed   = (op == op_div) || (op == op_rem);

    alu_shifter u_shifter (
        .value   (op1),
        .shamt   (op2[shamt_w-1:0]),
        .kind    (shift_kind),
        .shifted (shifted)
    );

    alu_multiplier u_multiplier (
        .a        (op1),
        .b        (op2),
        .a_signed (mul_a_signed),
        .b_signed (mul_b_signed),
        .product  (product)
    );

    alu_divider u_divider (
        .dividend  (op1),
        .divisor   (op2),
        .is_signed (div_signed),
        .quotient  (quotient),
        .remainder (remainder)
    );

    always_comb begin
        illegal = 1'b0;
        case (op)
            op_add:    result = sum;
            op_sub:    result = diff;
            op_and:    result = op1 & op2;
            op_or:     result = op1 | op2;
            op_xor:    result = op1 ^ op2;
            op_slt:    result = {{(xlen-1){1'b0}}, lt_s};
            op_sltu:   result = {{(xlen-1){1'b0}}, lt_u};
            op_sll, op_srl, op_sra: result = shifted;
            op_mul:    result = product[xlen-1:0];
            op_mulh, op_mulhu, op_mulhsu: result = product[2*xlen-1:xlen];
            op_div, op_divu: result = quotient;
            op_rem, op_remu: result = remainder;
            default: begin
                result  = '0; // unassigned code.
                illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/alu_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_divider (
    input  wire logic [alu_pkg::xlen-1:0] dividend,
    input  wire logic [alu_pkg::xlen-1:0] divisor,
    input  wire logic                     is_signed,
    output logic      [alu_pkg::xlen-1:0] quotient,
    output logic      [alu_pkg::xlen-1:0] remainder
);
    import alu_pkg::*;

    logic            a_neg;
    logic            b_neg;
    logic [xlen-1:0] a_mag;
    logic [xlen-1:0] b_mag;
    logic [xlen-1:0] q_mag;
    logic [xlen-1:0] r_mag;
    logic [xlen-1:0] q_fix;
    logic [xlen-1:0] r_fix;
    logic            div_zero;
    logic            overflow;

    assign a_neg = is_signed & dividend[xlen-1];
    assign b_neg = is_signed & divisor[xlen-1];

    assign a_mag = a_neg ? -dividend : dividend;
    assign b_mag = b_neg ? -divisor : divisor;

    assign div_zero = (divisor == '0);
    assign overflow = is_signed &&
                      (dividend == {1'b1, {(xlen-1){1'b0}}}) &&
                      (divisor == '1);

    // guarded so the unsigned core never sees a zero divisor.
    assign q_mag = div_zero ? '1 : a_mag / b_mag;
    assign r_mag = div_zero ? a_mag : a_mag % b_mag;

    assign q_fix = (a_neg ^ b_neg) ? -q_mag : q_mag;
    assign r_fix = a_neg ? -r_mag : r_mag; // remainder follows dividend.

    always_comb begin
        if (div_zero) begin
            quotient  = '1;
            remainder = dividend;
        end else if (overflow) begin
            quotient  = dividend;
            remainder = '0;
        end else begin
            quotient  = q_fix;
            remainder = r_fix;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/alu_multiplier.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_multiplier (
    input  wire logic [alu_pkg::xlen-1:0]   a,
    input  wire logic [alu_pkg::xlen-1:0]   b,
    input  wire logic                       a_signed,
    input  wire logic                       b_signed,
    output logic      [2*alu_pkg::xlen-1:0] product
);
    import alu_pkg::*;

    logic signed [2*xlen+1:0]   a_ext;
    logic signed [2*xlen+1:0]   b_ext;
    logic signed [2*xlen+1:0]   full;

    // sign or zero fill turns every operand into a signed 33-bit value.
    assign a_ext = {{(xlen+2){a_signed & a[xlen-1]}}, a};
    assign b_ext = {{(xlen+2){b_signed & b[xlen-1]}}, b};

    assign full    = a_ext * b_ext;
    assign product = full[2*xlen-1:0]; // upper bits are sign copies.

endmodule

`default_nettype wire

// ==== hdl/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

    localparam int xlen    = 32;
    localparam int op_w    = 5;
    localparam int shamt_w = 5;

    // shifter kind encoding.
    localparam logic [1:0] shift_sll = 2'd0;
    localparam logic [1:0] shift_srl = 2'd1;
    localparam logic [1:0] shift_sra = 2'd2;

    // codes 18 to 31 are not assigned.
    typedef enum logic [op_w-1:0] {
        op_add    = 5'd0,
        op_sub    = 5'd1,
        op_and    = 5'd2,
        op_or     = 5'd3,
        op_xor    = 5'd4,
        op_slt    = 5'd5,
        op_sltu   = 5'd6,
        op_sll    = 5'd7,
        op_srl    = 5'd8,
        op_sra    = 5'd9,
        op_mul    = 5'd10,
        op_mulh   = 5'd11,
        op_mulhu  = 5'd12,
        op_mulhsu = 5'd13,
        op_div    = 5'd14,
        op_divu   = 5'd15,
        op_rem    = 5'd16,
        op_remu   = 5'd17
    } alu_op_t;

endpackage

`default_nettype wire

// ==== hdl/alu_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_shifter (
    input  wire logic [alu_pkg::xlen-1:0]    value,
    input  wire logic [alu_pkg::shamt_w-1:0] shamt,
    input  wire logic [1:0]                  kind,
    output logic      [alu_pkg::xlen-1:0]    shifted
);
    import alu_pkg::*;

    logic [xlen-1:0] level [0:shamt_w];
    logic            left;
    logic            fill;

    assign left = (kind == shift_sll);
    assign fill = (kind == shift_sra) & value[xlen-1]; // sign fill for sra only.

    // left shifts run through the right shifter on a reversed word.
    assign level[0] = left ? {<<{value}} : value;

    for (genvar i = 0; i < shamt_w; i++) begin : g_level
        assign level[i+1] = shamt[i] ?
                            {{(2**i){fill}}, level[i][xlen-1:2**i]} :
                            level[i];
    end

    assign shifted = left ? {<<{level[shamt_w]}} : level[shamt_w];

endmodule

`default_nettype wire

// ==== hdl/alu_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_stage (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    input  wire logic                     in_valid,
    input  wire alu_pkg::alu_op_t         op,
    input  wire logic [alu_pkg::xlen-1:0] op1,
    input  wire logic [alu_pkg::xlen-1:0] op2,
    output logic                          out_valid,
    output logic      [alu_pkg::xlen-1:0] result,
    output logic                          illegal
);
    import alu_pkg::*;

    alu_op_t         op_q;
    logic [xlen-1:0] op1_q;
    logic [xlen-1:0] op2_q;
    logic            valid_q;
    logic [xlen-1:0] core_result;
    logic            core_illegal;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            op_q  <= op;
            op1_q <= op1;
            op2_q <= op2;
        end
    end

    alu_core u_core (
        .op      (op_q),
        .op1     (op1_q),
        .op2     (op2_q),
        .result  (core_result),
        .illegal (core_illegal)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
            illegal   <= 1'b0;
        end else begin
            out_valid <= valid_q;
            illegal   <= valid_q & core_illegal; // flag only with the strobe.
            if (valid_q) begin
                result <= core_result; // held between strobes.
            end
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# builds the ALU testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module alu_tb -f compile.f -o alu_sim \
    && ./obj_dir/alu_sim | tee sim.log \
    && grep -q "^All tests passed!$" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// ==== tests/alu_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_properties (
    input wire logic                     clk,
    input wire logic                     arst_n,
    input wire logic                     in_valid,
    input wire logic                     out_valid,
    input wire logic [alu_pkg::xlen-1:0] result,
    input wire logic                     illegal
);

    // one strobe out for each strobe in, two edges later.
    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == $past(in_valid, 2))
        else $error("out_valid does not follow in_valid by two cycles");

    a_reset: assert property (@(posedge clk)
        !arst_n |-> (!out_valid && !illegal && result == '0))
        else $error("outputs not cleared while in reset");

    a_illegal: assert property (@(posedge clk)
        illegal |-> out_valid)
        else $error("illegal raised without out_valid");

endmodule

`default_nettype wire

// ==== tests/alu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_tb;
    import alu_pkg::*;

    localparam int max_cycles = 2000;
    localparam int rand_ops   = 1000;

    logic            clk;
    logic            arst_n;
    logic            in_valid;
    alu_op_t         op;
    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
    logic            out_valid;
    logic [xlen-1:0] result;
    logic            illegal;

    logic [31:0]     seed;
    int              errors;
    int              checks;
    int              cycles;
    int              due;
    logic [xlen:0]   expected;
    logic [xlen:0]   exp_q[$]; // {illegal, result} per operation sent.
    int              due_q[$]; // cycle on which each result must show.

    alu_stage uut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .op        (op),
        .op1       (op1),
        .op2       (op2),
        .out_valid (out_valid),
        .result    (result),
        .illegal   (illegal)
    );

    bind alu_stage alu_properties u_props (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .out_valid (out_valid),
        .result    (result),
        .illegal   (illegal)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // corner values show up often in the random run.
    function automatic logic [31:0] pick_operand(logic [31:0] r, logic [31:0] fresh);
        case (r[2:0])
            3'd0:    return 32'h0000_0000;
            3'd1:    return 32'hffff_ffff;
            3'd2:    return 32'h8000_0000;
            3'd3:    return {27'd0, fresh[4:0]}; // small value.
            default: return fresh;
        endcase
    endfunction

    // expected {illegal, result} from 64-bit arithmetic.
    function automatic logic [xlen:0] expect_alu(alu_op_t code, logic [31:0] a,
                                                 logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] ua;
        logic signed [63:0] ub;
        logic [63:0]        shl;
        logic [63:0]        shr;
        logic [63:0]        sar;
        logic [63:0]        prod_ss;
        logic [63:0]        prod_uu;
        logic [63:0]        prod_su;
        logic [63:0]        quo_s;
        logic [63:0]        rem_s;
        logic [63:0]        quo_u;
        logic [63:0]        rem_u;
        logic [31:0]        res;
        logic               bad;
        sa      = {{32{a[31]}}, a};
        sb      = {{32{b[31]}}, b};
        ua      = {32'd0, a};
        ub      = {32'd0, b};
        shl     = ua << b[4:0];
        shr     = ua >> b[4:0];
        sar     = sa >> b[4:0]; // upper copies fill.
        prod_ss = sa * sb;
        prod_uu = ua * ub;
        prod_su = sa * ub;
        quo_s   = '0;
        rem_s   = '0;
        quo_u   = '0;
        rem_u   = '0;
        res     = '0;
        bad     = 1'b0;
        if (b != 32'd0) begin
            quo_s = sa / sb; // -2^31 / -1 wraps to the dividend.
            rem_s = sa % sb;
            quo_u = ua / ub;
            rem_u = ua % ub;
        end
        case (code)
            op_add:    res = a + b;
            op_sub:    res = a - b;
            op_and:    res = a & b;
            op_or:     res = a | b;
            op_xor:    res = a ^ b;
            op_slt:    res = {31'd0, sa < sb};
            op_sltu:   res = {31'd0, ua < ub};
            op_sll:    res = shl[31:0];
            op_srl:    res = shr[31:0];
            op_sra:    res = sar[31:0];
            op_mul:    res = prod_ss[31:0];
            op_mulh:   res = prod_ss[63:32];
            op_mulhu:  res = prod_uu[63:32];
            op_mulhsu: res = prod_su[63:32];
            op_div:    res = (b == 32'd0) ? 32'hffff_ffff : quo_s[31:0];
            op_divu:   res = (b == 32'd0) ? 32'hffff_ffff : quo_u[31:0];
            op_rem:    res = (b == 32'd0) ? a : rem_s[31:0];
            op_remu:   res = (b == 32'd0) ? a : rem_u[31:0];
            default:   bad = 1'b1;
        endcase
        return {bad, res};
    endfunction

    // called on a falling edge, returns on the next one.
    task automatic send_op(alu_op_t code, logic [31:0] a, logic [31:0] b);
        in_valid = 1'b1;
        op       = code;
        op1      = a;
        op2      = b;
        exp_q.push_back(expect_alu(code, a, b));
        due_q.push_back(cycles + 2);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic idle_cycles(int n);
        in_valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    // outputs settle after the rising edge.
    always @(negedge clk) begin
        if (!arst_n) begin
            assert (!out_valid && !illegal && result == '0) else begin
                errors++;
                $display("error reset outputs: out_valid %h illegal %h result %h",
                         out_valid, illegal, result);
            end
        end else if (out_valid) begin
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("out_valid pulsed with no operation outstanding");
            end
            if (exp_q.size() != 0) begin
                expected = exp_q.pop_front();
                due      = due_q.pop_front();
                checks++;
                assert (cycles == due) else begin
                    errors++;
                    $display("result came at cycle %0d instead of cycle %0d", cycles, due);
                end
                assert (result == expected[xlen-1:0]) else begin
                    errors++;
                    $display("error result: got %h expected %h", result, expected[xlen-1:0]);
                end
                assert (illegal == expected[xlen]) else begin
                    errors++;
                    $display("error illegal: got %h expected %h", illegal, expected[xlen]);
                end
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  code;
        clk      = 1'b0;
        arst_n   = 1'b1;
        in_valid = 1'b0;
        op       = op_add;
        op1      = '0;
        op2      = '0;
        seed     = 32'h593a_5d87;
        errors   = 0;
        checks   = 0;
        cycles   = 0;
        #1 arst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        idle_cycles(4); // no strobe may appear here.
        assert (!out_valid && !illegal && result == '0) else begin
            errors++;
            $display("error after reset: out_valid %h illegal %h result %h",
                     out_valid, illegal, result);
        end

        send_op(op_add, 32'h7fff_ffff, 32'h0000_0001);
        send_op(op_add, 32'hffff_ffff, 32'h0000_0001);
        send_op(op_sub, 32'h8000_0000, 32'h0000_0001);
        send_op(op_sub, 32'h0000_0000, 32'h0000_0001);
        send_op(op_and, 32'hf0f0_a5a5, 32'h0ff0_ffff);
        send_op(op_or,  32'hf0f0_0000, 32'h0f0f_1234);
        send_op(op_xor, 32'haaaa_5555, 32'hffff_0000);
        send_op(op_slt,  32'hffff_ffff, 32'h0000_0001);
        send_op(op_sltu, 32'hffff_ffff, 32'h0000_0001);
        send_op(op_sll, 32'h8000_0001, 32'h0000_0000);
        send_op(op_sll, 32'h0000_0003, 32'hffff_ffff); // only bits 4:0 count.
        send_op(op_srl, 32'h8000_0000, 32'h0000_001f);
        send_op(op_srl, 32'hdead_beef, 32'h0000_0000);
        send_op(op_sra, 32'h8000_0000, 32'h0000_001f);
        send_op(op_sra, 32'hf000_0000, 32'h0000_0004);
        send_op(op_mul, 32'h7fff_ffff, 32'h0000_0002);
        for (int i = 0; i < 4; i++) begin
            a = i[1] ? 32'hffff_ffff : 32'h8000_0000;
            b = i[0] ? 32'hffff_ffff : 32'h8000_0000;
            send_op(op_mulh, a, b);
            send_op(op_mulhu, a, b);
            send_op(op_mulhsu, a, b);
            send_op(op_mul, a, b);
        end
        send_op(op_div,  32'h1234_5678, 32'h0000_0000);
        send_op(op_divu, 32'h8000_0000, 32'h0000_0000);
        send_op(op_rem,  32'h8765_4321, 32'h0000_0000);
        send_op(op_remu, 32'h1234_5678, 32'h0000_0000);
        send_op(op_div,  32'h8000_0000, 32'hffff_ffff);
        send_op(op_rem,  32'h8000_0000, 32'hffff_ffff);
        send_op(op_div,  32'hffff_fff9, 32'h0000_0002); // -7 / 2.
        send_op(op_rem,  32'hffff_fff9, 32'h0000_0002);
        send_op(op_divu, 32'hffff_fff9, 32'h0000_0002);
        send_op(op_remu, 32'hffff_fff9, 32'h0000_0002);
        idle_cycles(3);

        for (int i = 0; i < rand_ops; i++) begin
            code = 5'((lcg_next() >> 8) % 32'd18);
            r    = lcg_next();
            a    = pick_operand(r, lcg_next());
            b    = pick_operand(r >> 3, lcg_next());
            send_op(alu_op_t'(code), a, b);
            if (r[31:28] < 4'd3) begin
                idle_cycles(1);
            end
        end
        idle_cycles(2);

        for (int c = 18; c < 32; c++) begin
            send_op(alu_op_t'(5'(c)), lcg_next(), lcg_next());
        end

        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        idle_cycles(4);
        $display("checks %0d, errors %0d, pending %0d", checks, errors, exp_q.size());
        if (errors == 0 && exp_q.size() == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
